/* vlog.f */
core_pkg.sv
csr_pkg.sv
gpr_file.sv
csr_file.sv
wb_ctrl.sv
wb_top.sv
wb_checker.sv
tb_wb.sv

/* Bender.yml */
package:
  name: wb_subsystem

sources:
  - core_pkg.sv
  - csr_pkg.sv
  - gpr_file.sv
  - csr_file.sv
  - wb_ctrl.sv
  - wb_top.sv
  - target: test
    files:
      - wb_checker.sv
      - tb_wb.sv

/* tb_wb.sv */
`timescale 1ns/1ps

module tb_wb;

    import core_pkg::*;
    import csr_pkg::*;

    typedef struct packed {
        logic [7:0] test;
        logic       valid;  // low marks an idle gap
        wb_op_t     op;
        logic [4:0] rd;
        word_t      result;
        csr_addr_t  csr;
        word_t      wdata;
        word_t      pc;
        logic       redir;  // expected redirect one cycle later
    } row_t;

    logic       clk;
    logic       reset;
    logic       ex_valid;
    wb_op_t     ex_op;
    logic [4:0] ex_rd;
    word_t      ex_result;
    csr_addr_t  ex_csr_addr;
    word_t      ex_csr_wdata;
    word_t      ex_pc;
    logic       wb_ready;
    logic [4:0] rs1_addr;
    word_t      rs1_data;
    logic [4:0] rs2_addr;
    word_t      rs2_data;
    csr_addr_t  csr_raddr;
    word_t      csr_rdata;
    logic       retire;
    logic       redirect_valid;
    word_t      redirect_pc;
    logic [7:0] test_id;
    logic       exp_redirect;
    logic       end_run;
    logic       finished;
    int         errors;

    row_t        table_q[$];
    logic [31:0] lfsr;
    word_t       next_pc;
    int          cycles;
    int          limit;

    wb_top #(.reg_addr_width(5)) dut (.*);

    wb_checker chk (.*);

    always #20 clk = ~clk;

    // ##################################################
    // stimulus helpers
    // ##################################################

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic add_row(input logic [7:0] test, input logic valid, input wb_op_t op,
                           input logic [4:0] rd, input word_t result, input csr_addr_t csr,
                           input word_t wdata, input logic redir);
        row_t r;
        r = {test, valid, op, rd, result, csr, wdata, next_pc, redir};
        table_q.push_back(r);
        next_pc += xlen_bytes;
    endtask

    task automatic add_random_alu(input logic [7:0] test);
        logic [31:0] rd;
        logic [31:0] res;
        draw_bits(5, rd);
        draw_bits(32, res);
        add_row(test, 1'b1, wb_alu, rd[4:0], res, 12'h000, '0, 1'b0);
    endtask

    task automatic build_table();
        // test 0 probes the csrs after reset with idle rows
        add_row(0, 1'b0, wb_alu, 5'd0, '0, csr_mstatus, '0, 1'b0);
        add_row(0, 1'b0, wb_alu, 5'd0, '0, csr_mtvec, '0, 1'b0);
        add_row(0, 1'b0, wb_alu, 5'd0, '0, csr_mepc, '0, 1'b0);
        add_row(0, 1'b0, wb_alu, 5'd0, '0, csr_mcause, '0, 1'b0);
        // test 1 runs back to back alu rows ending on x0
        repeat (6) add_random_alu(1);
        add_row(1, 1'b1, wb_alu, 5'd0, 32'hdead_beef, 12'h000, '0, 1'b0);
        // test 2 writes each csr and then an unknown address
        add_row(2, 1'b1, wb_csrrw, 5'd5, 32'h0000_0011, csr_mtvec, 32'h0000_0800, 1'b0);
        add_row(2, 1'b1, wb_csrrw, 5'd6, 32'h0000_0022, csr_mepc, 32'h0000_0300, 1'b0);
        add_row(2, 1'b0, wb_alu, 5'd5, '0, csr_mtvec, '0, 1'b0);
        add_row(2, 1'b1, wb_csrrw, 5'd7, 32'h0000_0033, csr_mcause, 32'h0000_0005, 1'b0);
        add_row(2, 1'b1, wb_csrrw, 5'd8, 32'h0000_0044, csr_mstatus, 32'h0000_1808, 1'b0);
        add_row(2, 1'b1, wb_csrrw, 5'd9, 32'h0000_0055, 12'h7c0, 32'hcafe_f00d, 1'b0);
        // test 3 takes an ecall and probes the trap state
        add_row(3, 1'b1, wb_ecall, 5'd0, '0, csr_mepc, '0, 1'b1);
        add_row(3, 1'b0, wb_alu, 5'd0, '0, csr_mcause, '0, 1'b0);
        add_row(3, 1'b0, wb_alu, 5'd0, '0, csr_mstatus, '0, 1'b0);
        // test 4 returns with mret
        add_row(4, 1'b1, wb_mret, 5'd0, '0, csr_mstatus, '0, 1'b1);
        add_row(4, 1'b0, wb_alu, 5'd0, '0, csr_mepc, '0, 1'b0);
        // test 5 clears mie and runs ecall and mret back to back
        add_row(5, 1'b1, wb_csrrw, 5'd10, 32'h0000_0066, csr_mstatus, 32'h0000_1880, 1'b0);
        add_row(5, 1'b1, wb_ecall, 5'd0, '0, csr_mstatus, '0, 1'b1);
        add_row(5, 1'b1, wb_mret, 5'd0, '0, csr_mstatus, '0, 1'b1);
        add_row(5, 1'b1, wb_alu, 5'd3, 32'h1234_5678, csr_mcause, '0, 1'b0);
    endtask

    // ##################################################
    // run control
    // ##################################################

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        ex_valid     = 1'b0;
        ex_op        = wb_alu;
        ex_rd        = '0;
        ex_result    = '0;
        ex_csr_addr  = '0;
        ex_csr_wdata = '0;
        ex_pc        = '0;
        test_id      = '0;
        exp_redirect = 1'b0;
        end_run      = 1'b0;
        cycles       = 0;
        lfsr         = 32'd6;
        next_pc      = 32'h0000_0100;
        build_table();
        limit = 10 + 2 * table_q.size() + 20;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        foreach (table_q[i]) begin
            @(posedge clk);
            test_id      <= table_q[i].test;
            ex_valid     <= table_q[i].valid;
            ex_op        <= table_q[i].op;
            ex_rd        <= table_q[i].rd;
            ex_result    <= table_q[i].result;
            ex_csr_addr  <= table_q[i].csr;
            ex_csr_wdata <= table_q[i].wdata;
            ex_pc        <= table_q[i].pc;
            exp_redirect <= table_q[i].redir;
        end
        @(posedge clk);
        ex_valid     <= 1'b0;
        exp_redirect <= 1'b0;
        end_run      <= 1'b1;
        while (!finished) @(posedge clk);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display(">>> FAIL");
            $finish;
        end
    end

endmodule

/* wb_checker.sv */
`timescale 1ns/1ps

module wb_checker (
    input  logic               clk,
    input  logic               reset,
    input  logic               ex_valid,
    input  core_pkg::wb_op_t   ex_op,
    input  logic [4:0]         ex_rd,
    input  core_pkg::word_t    ex_result,
    input  csr_pkg::csr_addr_t ex_csr_addr,
    input  core_pkg::word_t    ex_csr_wdata,
    input  core_pkg::word_t    ex_pc,
    input  logic               wb_ready,
    input  logic               retire,
    input  logic               redirect_valid,
    input  core_pkg::word_t    redirect_pc,
    output logic [4:0]         rs1_addr,
    input  core_pkg::word_t    rs1_data,
    output logic [4:0]         rs2_addr,
    input  core_pkg::word_t    rs2_data,
    output csr_pkg::csr_addr_t csr_raddr,
    input  core_pkg::word_t    csr_rdata,
    input  logic [7:0]         test_id,
    input  logic               exp_redirect,
    input  logic               end_run,
    output logic               finished,
    output int                 errors
);

    import core_pkg::*;
    import csr_pkg::*;

    word_t      gpr [32];
    logic       known [32];  // gprs are undefined until written
    word_t      m_mstatus;
    word_t      m_mtvec;
    word_t      m_mepc;
    word_t      m_mcause;
    logic       exp_retire;
    logic       exp_rv;
    word_t      exp_rpc;
    logic [7:0] tid_q;
    logic [7:0] cur_tid;
    logic       end_q;
    int         test_errs;
    int         checks;
    int         passed;
    int         failed;

    function automatic word_t csr_model(input csr_addr_t a);
        case (a)
            csr_mstatus: return m_mstatus;
            csr_mtvec:   return m_mtvec;
            csr_mepc:    return m_mepc;
            csr_mcause:  return m_mcause;
            default:     return '0;
        endcase
    endfunction

    task automatic compare_value(input string what, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            $display("[FAIL] t=%0t test %0d %s got %h expected %h", $time, tid_q, what, got, exp);
            test_errs++;
            errors++;
        end
    endtask

    initial begin
        for (int i = 0; i < 32; i++) known[i] = 1'b0;
        gpr[0]    = '0;
        known[0]  = 1'b1;  // x0 always zero
        rs1_addr  = '0;
        rs2_addr  = '0;
        csr_raddr = '0;
        tid_q     = '0;
        cur_tid   = '0;
        end_q     = 1'b0;
        finished  = 1'b0;
        errors    = 0;
        test_errs = 0;
        checks    = 0;
        passed    = 0;
        failed    = 0;
    end

    // ##################################################
    // reference model updated on the commit edge
    // ##################################################

    always @(posedge clk) begin : model_update
        word_t ms;
        tid_q     <= test_id;
        end_q     <= end_run;
        rs1_addr  <= ex_rd;  // read back what this row touches
        rs2_addr  <= rs1_addr;  // rd of the previous row
        csr_raddr <= ex_csr_addr;
        ms = m_mstatus;
        if (reset) begin
            m_mstatus = mstatus_reset;
            m_mtvec   = '0;
            m_mepc    = '0;
            m_mcause  = '0;
            exp_retire <= 1'b0;
            exp_rv     <= 1'b0;
        end else begin
            exp_retire <= ex_valid;
            exp_rv     <= ex_valid & exp_redirect;
            if (ex_valid && (ex_op == wb_alu || ex_op == wb_csrrw) && ex_rd != 0) begin
                gpr[ex_rd]   = ex_result;
                known[ex_rd] = 1'b1;
            end
            if (ex_valid && ex_op == wb_csrrw) begin
                case (ex_csr_addr)
                    csr_mstatus: m_mstatus = ex_csr_wdata;
                    csr_mtvec:   m_mtvec = ex_csr_wdata;
                    csr_mepc:    m_mepc = ex_csr_wdata;
                    csr_mcause:  m_mcause = ex_csr_wdata;
                    default:     ;  // unimplemented address dropped
                endcase
            end else if (ex_valid && ex_op == wb_ecall) begin
                exp_rpc <= m_mtvec;
                m_mepc   = ex_pc;
                m_mcause = cause_ecall_m;
                ms[mstatus_mpie] = m_mstatus[mstatus_mie];
                ms[mstatus_mie]  = 1'b0;
                m_mstatus = ms;
            end else if (ex_valid && ex_op == wb_mret) begin
                exp_rpc <= m_mepc;
                ms[mstatus_mie]  = m_mstatus[mstatus_mpie];
                ms[mstatus_mpie] = 1'b1;
                m_mstatus = ms;
            end
        end
    end

    // ##################################################
    // compare in the middle of the cycle
    // ##################################################

    always @(negedge clk) begin
        if (!reset && !finished) begin
            if (tid_q != cur_tid || end_q) begin
                if (test_errs == 0) begin
                    $display("test %0d: ok", cur_tid);
                    passed++;
                end else begin
                    $display("test %0d: %0d errors", cur_tid, test_errs);
                    failed++;
                end
                cur_tid   = tid_q;
                test_errs = 0;
            end
            if (end_q) begin
                $display("%0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
                         passed + failed, passed, failed, checks, errors);
                finished = 1'b1;
            end else begin
                compare_value("wb_ready", wb_ready, 1);
                compare_value("retire", retire, exp_retire);
                compare_value("redirect_valid", redirect_valid, exp_rv);
                if (exp_rv) compare_value("redirect_pc", redirect_pc, exp_rpc);
                if (known[rs1_addr]) compare_value("rs1_data", rs1_data, gpr[rs1_addr]);
                if (known[rs2_addr]) compare_value("rs2_data", rs2_data, gpr[rs2_addr]);
                compare_value("csr_rdata", csr_rdata, csr_model(csr_raddr));
            end
        end
    end

endmodule

/* wb_top.sv */
`timescale 1ns/1ps

module wb_top #(
    parameter int unsigned reg_addr_width = 5
) (
    input  logic                      clk,
    input  logic                      reset,
    // execute side
    input  logic                      ex_valid,
    input  core_pkg::wb_op_t          ex_op,
    input  logic [reg_addr_width-1:0] ex_rd,
    input  core_pkg::word_t           ex_result,
    input  csr_pkg::csr_addr_t        ex_csr_addr,
    input  core_pkg::word_t           ex_csr_wdata,
    input  core_pkg::word_t           ex_pc,
    output logic                      wb_ready,
    // read ports for decode and execute
    input  logic [reg_addr_width-1:0] rs1_addr,
    output core_pkg::word_t           rs1_data,
    input  logic [reg_addr_width-1:0] rs2_addr,
    output core_pkg::word_t           rs2_data,
    input  csr_pkg::csr_addr_t        csr_raddr,
    output core_pkg::word_t           csr_rdata,
    // retirement
    output logic                      retire,
    output logic                      redirect_valid,
    output core_pkg::word_t           redirect_pc
);

    import core_pkg::*;
    import csr_pkg::*;

    logic                      gpr_wen;
    logic [reg_addr_width-1:0] gpr_waddr;
    word_t                     gpr_wdata;

    logic      csr_wen;
    csr_addr_t csr_waddr1;
    word_t     csr_wdata1;
    csr_addr_t csr_waddr2;
    word_t     csr_wdata2;
    csr_addr_t csr_waddr3;
    word_t     csr_wdata3;

    word_t mstatus;
    word_t mtvec;
    word_t mepc;

    wb_ctrl #(
        .reg_addr_width(reg_addr_width)
    ) u_ctrl (
        .clk           (clk),
        .reset         (reset),
        .ex_valid      (ex_valid),
        .ex_op         (ex_op),
        .ex_rd         (ex_rd),
        .ex_result     (ex_result),
        .ex_csr_addr   (ex_csr_addr),
        .ex_csr_wdata  (ex_csr_wdata),
        .ex_pc         (ex_pc),
        .gpr_wen       (gpr_wen),
        .gpr_waddr     (gpr_waddr),
        .gpr_wdata     (gpr_wdata),
        .csr_wen       (csr_wen),
        .csr_waddr1    (csr_waddr1),
        .csr_wdata1    (csr_wdata1),
        .csr_waddr2    (csr_waddr2),
        .csr_wdata2    (csr_wdata2),
        .csr_waddr3    (csr_waddr3),
        .csr_wdata3    (csr_wdata3),
        .mstatus       (mstatus),
        .mtvec         (mtvec),
        .mepc          (mepc),
        .wb_ready      (wb_ready),
        .retire        (retire),
        .redirect_valid(redirect_valid),
        .redirect_pc   (redirect_pc)
    );

    gpr_file #(
        .reg_addr_width(reg_addr_width)
    ) u_gpr (
        .clk   (clk),
        .wen   (gpr_wen),
        .waddr (gpr_waddr),
        .wdata (gpr_wdata),
        .raddr1(rs1_addr),
        .raddr2(rs2_addr),
        .rdata1(rs1_data),
        .rdata2(rs2_data)
    );

    csr_file u_csr (
        .clk    (clk),
        .reset  (reset),
        .wen    (csr_wen),
        .waddr1 (csr_waddr1),
        .wdata1 (csr_wdata1),
        .waddr2 (csr_waddr2),
        .wdata2 (csr_wdata2),
        .waddr3 (csr_waddr3),
        .wdata3 (csr_wdata3),
        .raddr  (csr_raddr),
        .rdata  (csr_rdata),
        .mstatus(mstatus),
        .mtvec  (mtvec),
        .mepc   (mepc)
    );

endmodule

/* wb_ctrl.sv */
`timescale 1ns/1ps

module wb_ctrl #(
    parameter int unsigned reg_addr_width = 5
) (
    input  logic                      clk,
    input  logic                      reset,
    // execute side
    input  logic                      ex_valid,
    input  core_pkg::wb_op_t          ex_op,
    input  logic [reg_addr_width-1:0] ex_rd,
    input  core_pkg::word_t           ex_result,
    input  csr_pkg::csr_addr_t        ex_csr_addr,
    input  core_pkg::word_t           ex_csr_wdata,
    input  core_pkg::word_t           ex_pc,
    // gpr write port
    output logic                      gpr_wen,
    output logic [reg_addr_width-1:0] gpr_waddr,
    output core_pkg::word_t           gpr_wdata,
    // csr write ports
    output logic                      csr_wen,
    output csr_pkg::csr_addr_t        csr_waddr1,
    output core_pkg::word_t           csr_wdata1,
    output csr_pkg::csr_addr_t        csr_waddr2,
    output core_pkg::word_t           csr_wdata2,
    output csr_pkg::csr_addr_t        csr_waddr3,
    output core_pkg::word_t           csr_wdata3,
    // current trap state
    input  core_pkg::word_t           mstatus,
    input  core_pkg::word_t           mtvec,
    input  core_pkg::word_t           mepc,
    // pipeline status
    output logic                      wb_ready,
    output logic                      retire,
    output logic                      redirect_valid,
    output core_pkg::word_t           redirect_pc
);

    import core_pkg::*;
    import csr_pkg::*;

    // no csr lives here, parks unused write ports
    localparam csr_addr_t csr_idle = 12'h000;

    logic  is_alu;
    logic  is_csrrw;
    logic  is_ecall;
    logic  is_mret;
    word_t mstatus_trap;
    word_t mstatus_ret;

    assign is_alu   = (ex_op == wb_alu);
    assign is_csrrw = (ex_op == wb_csrrw);
    assign is_ecall = (ex_op == wb_ecall);
    assign is_mret  = (ex_op == wb_mret);

    assign wb_ready = ~reset;  // never back-pressures

    // ##################################################
    // gpr writeback
    // ##################################################

    assign gpr_wen   = ex_valid & (is_alu | is_csrrw);
    assign gpr_waddr = ex_rd;
    assign gpr_wdata = ex_result;

    // ##################################################
    // mstatus on trap entry and return
    // ##################################################

    always_comb begin
        mstatus_trap               = mstatus;
        mstatus_trap[mstatus_mpie] = mstatus[mstatus_mie];
        mstatus_trap[mstatus_mie]  = 1'b0;

        mstatus_ret                = mstatus;
        mstatus_ret[mstatus_mie]   = mstatus[mstatus_mpie];
        mstatus_ret[mstatus_mpie]  = 1'b1;
    end

    // ##################################################
    // csr write ports
    // ##################################################

    assign csr_wen = ex_valid & (is_csrrw | is_ecall | is_mret);

    always_comb begin
        csr_waddr1 = csr_idle;
        csr_wdata1 = '0;
        csr_waddr2 = csr_idle;
        csr_wdata2 = '0;
        csr_waddr3 = csr_idle;
        csr_wdata3 = '0;
        case (ex_op)
            wb_csrrw: begin
                csr_waddr1 = ex_csr_addr;
                csr_wdata1 = ex_csr_wdata;
                csr_waddr3 = ex_csr_addr;  // only lands if it is mstatus
                csr_wdata3 = ex_csr_wdata;
            end
            wb_ecall: begin
                csr_waddr1 = csr_mepc;
                csr_wdata1 = ex_pc;
                csr_waddr2 = csr_mcause;
                csr_wdata2 = cause_ecall_m;
                csr_waddr3 = csr_mstatus;
                csr_wdata3 = mstatus_trap;
            end
            wb_mret: begin
                csr_waddr3 = csr_mstatus;
                csr_wdata3 = mstatus_ret;
            end
            default: begin
                // alu touches no csr
            end
        endcase
    end

    // ##################################################
    // retire and redirect, one cycle after the strobe
    // ##################################################

    always_ff @(posedge clk) begin
        if (reset) begin
            retire         <= 1'b0;
            redirect_valid <= 1'b0;
            redirect_pc    <= '0;
        end else begin
            retire         <= ex_valid;
            redirect_valid <= ex_valid & (is_ecall | is_mret);
            if (ex_valid & is_ecall) begin
                redirect_pc <= mtvec;  // target before this commit
            end else if (ex_valid & is_mret) begin
                redirect_pc <= mepc;
            end
        end
    end

endmodule

/* csr_file.sv */
`timescale 1ns/1ps

module csr_file (
    input  logic               clk,
    input  logic               reset,
    input  logic               wen,
    input  csr_pkg::csr_addr_t waddr1,
    input  core_pkg::word_t    wdata1,
    input  csr_pkg::csr_addr_t waddr2,
    input  core_pkg::word_t    wdata2,
    input  csr_pkg::csr_addr_t waddr3,
    input  core_pkg::word_t    wdata3,
    input  csr_pkg::csr_addr_t raddr,
    output core_pkg::word_t    rdata,
    output core_pkg::word_t    mstatus,
    output core_pkg::word_t    mtvec,
    output core_pkg::word_t    mepc
);

    import core_pkg::*;
    import csr_pkg::*;

    word_t mcause;

    logic hit_mstatus;
    logic hit_mtvec;
    logic hit_mepc;
    logic hit_mcause;

    // port 1 wins over port 2, otherwise hold
    function automatic word_t port_pick(
        input csr_addr_t addr,
        input word_t     cur,
        input csr_addr_t a1,
        input word_t     d1,
        input csr_addr_t a2,
        input word_t     d2
    );
        if (a1 == addr) begin
            return d1;
        end else if (a2 == addr) begin
            return d2;
        end
        return cur;
    endfunction

    // ##################################################
    // write side
    // ##################################################

    always_ff @(posedge clk) begin
        if (reset) begin
            mstatus <= mstatus_reset;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end else if (wen) begin
            if (waddr3 == csr_mstatus) begin  // mstatus only via port 3
                mstatus <= wdata3;
            end
            mtvec  <= port_pick(csr_mtvec, mtvec, waddr1, wdata1, waddr2, wdata2);
            mepc   <= port_pick(csr_mepc, mepc, waddr1, wdata1, waddr2, wdata2);
            mcause <= port_pick(csr_mcause, mcause, waddr1, wdata1, waddr2, wdata2);
        end
    end

    // ##################################################
    // read side
    // ##################################################

    assign hit_mstatus = (raddr == csr_mstatus);
    assign hit_mtvec   = (raddr == csr_mtvec);
    assign hit_mepc    = (raddr == csr_mepc);
    assign hit_mcause  = (raddr == csr_mcause);

    // and-or select, no hit reads zero
    assign rdata = ({$bits(word_t){hit_mstatus}} & mstatus) |
                   ({$bits(word_t){hit_mtvec}}   & mtvec)   |
                   ({$bits(word_t){hit_mepc}}    & mepc)    |
                   ({$bits(word_t){hit_mcause}}  & mcause);

endmodule

/* gpr_file.sv */
`timescale 1ns/1ps

module gpr_file #(
    parameter int unsigned reg_addr_width = 5
) (
    input  logic                      clk,
    input  logic                      wen,
    input  logic [reg_addr_width-1:0] waddr,
    input  core_pkg::word_t           wdata,
    input  logic [reg_addr_width-1:0] raddr1,
    input  logic [reg_addr_width-1:0] raddr2,
    output core_pkg::word_t           rdata1,
    output core_pkg::word_t           rdata2
);

    import core_pkg::*;

    localparam int unsigned num_regs = 2 ** reg_addr_width;

    word_t regs [num_regs];

    // ##################################################
    // write port
    // ##################################################

    always_ff @(posedge clk) begin
        if (wen) begin
            regs[waddr] <= wdata;
        end
        regs[0] <= '0;  // x0 hardwired, overrides any write to it
    end

    // ##################################################
    // read ports
    // ##################################################

    // asynchronous, write of this edge visible right after it
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

/* csr_pkg.sv */
package csr_pkg;

    // ##################################################
    // csr addresses
    // ##################################################

    typedef logic [11:0] csr_addr_t;

    localparam csr_addr_t csr_mstatus = 12'h300;
    localparam csr_addr_t csr_mtvec   = 12'h305;
    localparam csr_addr_t csr_mepc    = 12'h341;
    localparam csr_addr_t csr_mcause  = 12'h342;

    // ##################################################
    // mstatus layout
    // ##################################################

    localparam int unsigned mstatus_mie  = 3;  // global interrupt enable
    localparam int unsigned mstatus_mpie = 7;  // enable before the trap

    // mpp = 2'b11, machine mode only
    localparam logic [31:0] mstatus_reset = 32'h0000_1800;

    // ##################################################
    // trap causes
    // ##################################################

    // only synchronous cause handled here
    localparam logic [31:0] cause_ecall_m = 32'd11;  // ecall from m-mode

endpackage

/* core_pkg.sv */
package core_pkg;

    // ##################################################
    // datapath word
    // ##################################################

    typedef logic [31:0] word_t;

    localparam int unsigned xlen_bytes = $bits(word_t) / 8;  // pc step per instruction

    // ##################################################
    // writeback operation codes
    // ##################################################

    typedef logic [1:0] wb_op_t;

    localparam wb_op_t wb_alu   = 2'd0;  // result to rd
    localparam wb_op_t wb_csrrw = 2'd1;  // result to rd, write value to csr
    localparam wb_op_t wb_ecall = 2'd2;  // environment call trap
    localparam wb_op_t wb_mret  = 2'd3;  // return from trap

endpackage
